// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_soc_peripherals
FILELIST  = all.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
src/soc_periph_pkg.sv
src/periph_bus_decoder.sv
src/apb_gpio.sv
src/apb_timer_unit.sv
src/apb_wdt.sv
src/soc_event_router.sv
src/soc_peripherals.sv
tb/tb_soc_peripherals.sv

// ==== src/apb_gpio.sv ====
module apb_gpio #(
    parameter int NGPIO = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  soc_periph_pkg::apb_req_t apb_req_i,
    output soc_periph_pkg::apb_rsp_t apb_rsp_o,

    input  logic [NGPIO-1:0]         gpio_in_i,
    output logic [NGPIO-1:0]         gpio_out_o,
    output logic [NGPIO-1:0]         gpio_dir_o,
    output logic                     gpio_event_o
);

    import soc_periph_pkg::*;

    gpio_reg_e             reg_addr;
    logic                  wr_en;
    logic                  rd_en;
    logic [APB_DATA_W-1:0] rdata;

    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] inten_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] sync_q1;
    logic [NGPIO-1:0] sync_q2;
    logic [NGPIO-1:0] prev_q;
    logic [NGPIO-1:0] change;

    assign reg_addr = gpio_reg_e'(apb_req_i.paddr[7:0]);
    assign wr_en    = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign rd_en    = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

    // enabled pins whose synchronised level moved this cycle
    assign change       = (sync_q2 ^ prev_q) & inten_q;
    assign gpio_event_o = |change;

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
            sync_q1  <= '0;
            sync_q2  <= '0;
            prev_q   <= '0;
        end else begin
            sync_q1 <= gpio_in_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;

            if (wr_en && reg_addr == GPIO_DIR) begin
                dir_q <= apb_req_i.pwdata[NGPIO-1:0];
            end
            if (wr_en && reg_addr == GPIO_OUT) begin
                out_q <= apb_req_i.pwdata[NGPIO-1:0];
            end
            if (wr_en && reg_addr == GPIO_INTEN) begin
                inten_q <= apb_req_i.pwdata[NGPIO-1:0];
            end

            // a change in the read cycle survives the clear
            if (rd_en && reg_addr == GPIO_INTSTATUS) begin
                status_q <= change;
            end else begin
                status_q <= status_q | change;
            end
        end
    end

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////
    always_comb begin
        case (reg_addr)
            GPIO_DIR:       rdata = APB_DATA_W'(dir_q);
            GPIO_IN:        rdata = APB_DATA_W'(sync_q2);
            GPIO_OUT:       rdata = APB_DATA_W'(out_q);
            GPIO_INTEN:     rdata = APB_DATA_W'(inten_q);
            GPIO_INTSTATUS: rdata = APB_DATA_W'(status_q);
            default:        rdata = '0;
        endcase
    end

    assign apb_rsp_o  = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;

endmodule

// ==== src/apb_timer_unit.sv ====
module apb_timer_unit #(
    parameter int TIMER_W = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  soc_periph_pkg::apb_req_t apb_req_i,
    output soc_periph_pkg::apb_rsp_t apb_rsp_o,

    output logic                     timer_event_o
);

    import soc_periph_pkg::*;

    timer_reg_e            reg_addr;
    logic                  wr_en;
    logic [APB_DATA_W-1:0] rdata;

    logic               enable_q;
    logic [TIMER_W-1:0] count_q;
    logic [TIMER_W-1:0] cmp_q;
    logic               hit;

    assign reg_addr = timer_reg_e'(apb_req_i.paddr[7:0]);
    assign wr_en    = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    // compare match, the counter wraps on the following edge
    assign hit           = enable_q && (count_q == cmp_q);
    assign timer_event_o = hit;

    //////////////////////////////////////////////////
    // config and counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            cmp_q    <= '0;
        end else begin
            if (wr_en && reg_addr == TIMER_CFG) begin
                enable_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && reg_addr == TIMER_CMP) begin
                cmp_q <= apb_req_i.pwdata[TIMER_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (wr_en && reg_addr == TIMER_COUNT) begin
            // software write wins over counting
            count_q <= apb_req_i.pwdata[TIMER_W-1:0];
        end else if (hit) begin
            count_q <= '0;
        end else if (enable_q) begin
            count_q <= count_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////
    always_comb begin
        case (reg_addr)
            TIMER_CFG:   rdata = APB_DATA_W'(enable_q);
            TIMER_COUNT: rdata = APB_DATA_W'(count_q);
            TIMER_CMP:   rdata = APB_DATA_W'(cmp_q);
            default:     rdata = '0;
        endcase
    end

    assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

endmodule

// ==== src/apb_wdt.sv ====
module apb_wdt (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  soc_periph_pkg::apb_req_t apb_req_i,
    output soc_periph_pkg::apb_rsp_t apb_rsp_o,

    output logic                     wdt_reset_o
);

    import soc_periph_pkg::*;

    wdt_reg_e              reg_addr;
    logic                  wr_en;
    logic [APB_DATA_W-1:0] rdata;

    logic                  enable_q;
    logic [APB_DATA_W-1:0] reload_q;
    logic [APB_DATA_W-1:0] count_q;
    logic                  do_enable;
    logic                  do_kick;

    assign reg_addr = wdt_reg_e'(apb_req_i.paddr[7:0]);
    assign wr_en    = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    // both restart the countdown from the reload value
    assign do_enable = wr_en && reg_addr == WDT_CTRL && apb_req_i.pwdata[0];
    assign do_kick   = wr_en && reg_addr == WDT_KICK
                       && apb_req_i.pwdata[7:0] == WDT_KICK_KEY;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            reload_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en && reg_addr == WDT_CTRL) begin
                enable_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && reg_addr == WDT_RELOAD) begin
                reload_q <= apb_req_i.pwdata;
            end

            if (do_enable || do_kick) begin
                count_q <= reload_q;
            end else if (enable_q && count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            WDT_CTRL:   rdata = APB_DATA_W'(enable_q);
            WDT_RELOAD: rdata = reload_q;
            WDT_COUNT:  rdata = count_q;
            default:    rdata = '0;
        endcase
    end

    assign apb_rsp_o   = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
    // expired, held until a kick or disable
    assign wdt_reset_o = enable_q && (count_q == '0);

endmodule

// ==== src/periph_bus_decoder.sv ====
module periph_bus_decoder (
    input  soc_periph_pkg::apb_req_t apb_req_i,
    output soc_periph_pkg::apb_rsp_t apb_rsp_o,

    output soc_periph_pkg::apb_req_t gpio_req_o,
    output soc_periph_pkg::apb_req_t timer_req_o,
    output soc_periph_pkg::apb_req_t wdt_req_o,
    output soc_periph_pkg::apb_req_t evt_req_o,

    input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
    input  soc_periph_pkg::apb_rsp_t timer_rsp_i,
    input  soc_periph_pkg::apb_rsp_t wdt_rsp_i,
    input  soc_periph_pkg::apb_rsp_t evt_rsp_i
);

    import soc_periph_pkg::*;

    periph_e  region;
    apb_req_t req_base;

    assign region = periph_e'(apb_req_i.paddr[REGION_LSB +: 4]);

    always_comb begin
        // peers get the request with the region field cleared and psel low
        req_base                        = apb_req_i;
        req_base.paddr[REGION_LSB +: 4] = '0;
        req_base.psel                   = 1'b0;

        gpio_req_o  = req_base;
        timer_req_o = req_base;
        wdt_req_o   = req_base;
        evt_req_o   = req_base;

        apb_rsp_o = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};

        case (region)
            PERIPH_GPIO: begin
                gpio_req_o.psel = apb_req_i.psel;
                apb_rsp_o       = gpio_rsp_i;
            end
            PERIPH_TIMER: begin
                timer_req_o.psel = apb_req_i.psel;
                apb_rsp_o        = timer_rsp_i;
            end
            PERIPH_WDT: begin
                wdt_req_o.psel = apb_req_i.psel;
                apb_rsp_o      = wdt_rsp_i;
            end
            PERIPH_EVENT: begin
                evt_req_o.psel = apb_req_i.psel;
                apb_rsp_o      = evt_rsp_i;
            end
            default: begin
                // unmapped region, error flagged in the access phase
                apb_rsp_o.pslverr = apb_req_i.psel & apb_req_i.penable;
            end
        endcase
    end

endmodule

// ==== src/soc_event_router.sv ====
module soc_event_router (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,

    input  soc_periph_pkg::apb_req_t              apb_req_i,
    output soc_periph_pkg::apb_rsp_t              apb_rsp_o,

    input  logic                                  slow_clk_i,
    input  logic                                  gpio_event_i,
    input  logic                                  timer_event_i,
    output logic [soc_periph_pkg::FC_EVT_W-1:0]   fc_events_o
);

    import soc_periph_pkg::*;

    evt_reg_e              reg_addr;
    logic                  wr_en;
    logic [APB_DATA_W-1:0] rdata;

    logic [FC_EVT_W-1:0] mask_q;
    logic [FC_EVT_W-1:0] events_d;
    logic [FC_EVT_W-1:0] fc_events_q;
    // two synchroniser stages plus the previous level
    logic [2:0]          slow_q;
    logic                ref_edge;
    logic [EVT_SW_W-1:0] sw_trig;

    assign reg_addr = evt_reg_e'(apb_req_i.paddr[7:0]);
    assign wr_en    = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    assign ref_edge = slow_q[1] ^ slow_q[2];
    assign sw_trig  = (wr_en && reg_addr == EVT_SW_TRIG) ? apb_req_i.pwdata[EVT_SW_W-1:0] : '0;

    // place every source at its slot, unused bits stay low
    always_comb begin
        events_d                               = '0;
        events_d[EVT_SW_BASE +: EVT_SW_W]      = sw_trig;
        events_d[EVT_TIMER]                    = timer_event_i;
        events_d[EVT_GPIO]                     = gpio_event_i;
        events_d[EVT_REF_EDGE]                 = ref_edge;
    end

    //////////////////////////////////////////////////
    // mask and output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mask_q      <= '0;
            fc_events_q <= '0;
            slow_q      <= '0;
        end else begin
            slow_q      <= {slow_q[1:0], slow_clk_i};
            fc_events_q <= events_d & mask_q;
            if (wr_en && reg_addr == EVT_MASK) begin
                mask_q <= apb_req_i.pwdata[FC_EVT_W-1:0];
            end
        end
    end

    always_comb begin
        case (reg_addr)
            EVT_MASK: rdata = APB_DATA_W'(mask_q);
            default:  rdata = '0;
        endcase
    end

    assign apb_rsp_o   = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
    assign fc_events_o = fc_events_q;

endmodule

// ==== src/soc_periph_pkg.sv ====
package soc_periph_pkg;

    //////////////////////////////////////////////////
    // bus and vector widths
    //////////////////////////////////////////////////
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;
    localparam int FC_EVT_W   = 32;

    // paddr[15:12] selects the peripheral
    localparam int REGION_LSB = 12;

    localparam logic [7:0] WDT_KICK_KEY = 8'hA5;

    // number of software-triggered event bits
    localparam int EVT_SW_W = 8;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        PERIPH_GPIO  = 4'd0,
        PERIPH_TIMER = 4'd1,
        PERIPH_WDT   = 4'd2,
        PERIPH_EVENT = 4'd3
    } periph_e;

    typedef enum logic [7:0] {
        GPIO_DIR       = 8'h00,
        GPIO_IN        = 8'h04,
        GPIO_OUT       = 8'h08,
        GPIO_INTEN     = 8'h0C,
        GPIO_INTSTATUS = 8'h10
    } gpio_reg_e;

    typedef enum logic [7:0] {
        TIMER_CFG   = 8'h00,
        TIMER_COUNT = 8'h04,
        TIMER_CMP   = 8'h08
    } timer_reg_e;

    typedef enum logic [7:0] {
        WDT_CTRL   = 8'h00,
        WDT_RELOAD = 8'h04,
        WDT_KICK   = 8'h08,
        WDT_COUNT  = 8'h0C
    } wdt_reg_e;

    typedef enum logic [7:0] {
        EVT_MASK    = 8'h00,
        EVT_SW_TRIG = 8'h04
    } evt_reg_e;

    // bit positions in the fast-controller event vector
    typedef enum logic [4:0] {
        EVT_SW_BASE  = 5'd0,
        EVT_TIMER    = 5'd8,
        EVT_GPIO     = 5'd9,
        EVT_REF_EDGE = 5'd10
    } fc_event_e;

endpackage

// ==== src/soc_peripherals.sv ====
module soc_peripherals #(
    parameter int NGPIO   = 32,
    parameter int TIMER_W = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  soc_periph_pkg::apb_req_t            apb_req_i,
    output soc_periph_pkg::apb_rsp_t            apb_rsp_o,

    input  logic                                slow_clk_i,

    input  logic [NGPIO-1:0]                    gpio_in_i,
    output logic [NGPIO-1:0]                    gpio_out_o,
    output logic [NGPIO-1:0]                    gpio_dir_o,

    output logic [soc_periph_pkg::FC_EVT_W-1:0] fc_events_o,
    output logic                                wdt_reset_o
);

    import soc_periph_pkg::*;

    apb_req_t gpio_req;
    apb_req_t timer_req;
    apb_req_t wdt_req;
    apb_req_t evt_req;
    apb_rsp_t gpio_rsp;
    apb_rsp_t timer_rsp;
    apb_rsp_t wdt_rsp;
    apb_rsp_t evt_rsp;

    logic gpio_event;
    logic timer_event;

    //////////////////////////////////////////////////
    // bus decode
    //////////////////////////////////////////////////
    periph_bus_decoder periph_bus_decoder_inst (
        .apb_req_i   ( apb_req_i ),
        .apb_rsp_o   ( apb_rsp_o ),
        .gpio_req_o  ( gpio_req  ),
        .timer_req_o ( timer_req ),
        .wdt_req_o   ( wdt_req   ),
        .evt_req_o   ( evt_req   ),
        .gpio_rsp_i  ( gpio_rsp  ),
        .timer_rsp_i ( timer_rsp ),
        .wdt_rsp_i   ( wdt_rsp   ),
        .evt_rsp_i   ( evt_rsp   )
    );

    //////////////////////////////////////////////////
    // peripherals
    //////////////////////////////////////////////////
    apb_gpio #(
        .NGPIO ( NGPIO )
    ) apb_gpio_inst (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .apb_req_i    ( gpio_req   ),
        .apb_rsp_o    ( gpio_rsp   ),
        .gpio_in_i    ( gpio_in_i  ),
        .gpio_out_o   ( gpio_out_o ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    apb_timer_unit #(
        .TIMER_W ( TIMER_W )
    ) apb_timer_unit_inst (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .apb_req_i     ( timer_req   ),
        .apb_rsp_o     ( timer_rsp   ),
        .timer_event_o ( timer_event )
    );

    apb_wdt apb_wdt_inst (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .apb_req_i   ( wdt_req     ),
        .apb_rsp_o   ( wdt_rsp     ),
        .wdt_reset_o ( wdt_reset_o )
    );

    // builds the fast-controller event vector
    soc_event_router soc_event_router_inst (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .apb_req_i     ( evt_req     ),
        .apb_rsp_o     ( evt_rsp     ),
        .slow_clk_i    ( slow_clk_i  ),
        .gpio_event_i  ( gpio_event  ),
        .timer_event_i ( timer_event ),
        .fc_events_o   ( fc_events_o )
    );

endmodule

// ==== tb/tb_soc_peripherals.sv ====
module tb_soc_peripherals;

    timeunit 1ns;
    timeprecision 1ps;

    import soc_periph_pkg::*;

    localparam int NGPIO      = 32;
    localparam int TIMER_W    = 32;
    localparam int MAX_CYCLES = 100000;

    logic                clk_i      = 1'b0;
    logic                rst_n_i;
    apb_req_t            apb_req_i;
    apb_rsp_t            apb_rsp_o;
    logic                slow_clk_i = 1'b0;
    logic [NGPIO-1:0]    gpio_in_i;
    logic [NGPIO-1:0]    gpio_out_o;
    logic [NGPIO-1:0]    gpio_dir_o;
    logic [FC_EVT_W-1:0] fc_events_o;
    logic                wdt_reset_o;

    integer seed = 88;

    // reference model of the programmed registers
    logic [APB_DATA_W-1:0] dir_m;
    logic [APB_DATA_W-1:0] out_m;
    logic [APB_DATA_W-1:0] inten_m;
    logic [APB_DATA_W-1:0] mask_m;
    logic [APB_DATA_W-1:0] cmp_m;
    logic [APB_DATA_W-1:0] reload_m;

    soc_peripherals soc_peripherals_inst (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .apb_req_i   ( apb_req_i   ),
        .apb_rsp_o   ( apb_rsp_o   ),
        .slow_clk_i  ( slow_clk_i  ),
        .gpio_in_i   ( gpio_in_i   ),
        .gpio_out_o  ( gpio_out_o  ),
        .gpio_dir_o  ( gpio_dir_o  ),
        .fc_events_o ( fc_events_o ),
        .wdt_reset_o ( wdt_reset_o )
    );

    always #20 clk_i = ~clk_i;

    // reference clock toggles every 7 cycles
    always begin
        repeat (7) @(negedge clk_i);
        slow_clk_i <= ~slow_clk_i;
    end

    //////////////////////////////////////////////////
    // reporting and compare tasks
    //////////////////////////////////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input logic [APB_DATA_W-1:0] exp,
                              input logic [APB_DATA_W-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_events(input string name, input logic [FC_EVT_W-1:0] exp,
                                input logic [FC_EVT_W-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s: expected %b actual %b", name, exp, act));
        end
    endtask

    //////////////////////////////////////////////////
    // bus access tasks start on a falling edge
    //////////////////////////////////////////////////
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [APB_ADDR_W-1:0] reg_addr(input logic [3:0] region,
                                                       input logic [7:0] off);
        return (APB_ADDR_W'(region) << REGION_LSB) | APB_ADDR_W'(off);
    endfunction

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output apb_rsp_t rsp);
        apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk_i);
        apb_req_i.penable = 1'b1;
        // response is combinational in the access cycle
        #1;
        rsp = apb_rsp_o;
        @(negedge clk_i);
        apb_req_i = '0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output apb_rsp_t rsp);
        apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(negedge clk_i);
        apb_req_i.penable = 1'b1;
        #1;
        rsp = apb_rsp_o;
        @(negedge clk_i);
        apb_req_i = '0;
    endtask

    task automatic write_reg(input logic [3:0] region, input logic [7:0] off,
                             input logic [APB_DATA_W-1:0] data);
        apb_rsp_t rsp;
        apb_write(reg_addr(region, off), data, rsp);
        check_bit("write_pslverr", 1'b0, rsp.pslverr);
    endtask

    task automatic read_expect(input string name, input logic [3:0] region,
                               input logic [7:0] off, input logic [APB_DATA_W-1:0] exp);
        apb_rsp_t rsp;
        apb_rsp_t exp_rsp;
        exp_rsp = '{prdata: exp, pready: 1'b1, pslverr: 1'b0};
        apb_read(reg_addr(region, off), rsp);
        check_rsp(name, exp_rsp, rsp);
    endtask

    //////////////////////////////////////////////////
    // bounded waits
    //////////////////////////////////////////////////
    task automatic wait_event_bit(input int idx, input int max_cycles, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles = cycles + 1;
        end while (!fc_events_o[idx] && cycles < max_cycles);
        if (!fc_events_o[idx]) begin
            fail_run($sformatf("timeout while waiting for event bit %0d", idx));
        end
    endtask

    task automatic wait_slow_toggle(input int max_cycles);
        logic prev;
        int   n;
        prev = slow_clk_i;
        n    = 0;
        do begin
            @(posedge clk_i);
            n = n + 1;
        end while (slow_clk_i == prev && n < max_cycles);
        if (slow_clk_i == prev) begin
            fail_run("timeout while waiting for the reference clock to toggle");
        end
    endtask

    task automatic wait_wdt_reset(input int max_cycles);
        int n;
        n = 0;
        while (!wdt_reset_o && n < max_cycles) begin
            @(negedge clk_i);
            n = n + 1;
        end
        if (!wdt_reset_o) begin
            fail_run("watchdog reset did not rise in time");
        end
    endtask

    //////////////////////////////////////////////////
    // test sequences
    //////////////////////////////////////////////////
    task automatic registers_readback();
        logic [APB_DATA_W-1:0] gpio_mask;
        logic [APB_DATA_W-1:0] timer_mask;
        logic [APB_DATA_W-1:0] raw;
        gpio_mask  = {APB_DATA_W{1'b1}} >> (APB_DATA_W - NGPIO);
        timer_mask = {APB_DATA_W{1'b1}} >> (APB_DATA_W - TIMER_W);
        for (int i = 0; i < 8; i++) begin
            raw = rand32();
            write_reg(PERIPH_GPIO, GPIO_DIR, raw);
            dir_m = raw & gpio_mask;
            raw = rand32();
            write_reg(PERIPH_GPIO, GPIO_OUT, raw);
            out_m = raw & gpio_mask;
            check_data("gpio_dir_o", dir_m, APB_DATA_W'(gpio_dir_o));
            check_data("gpio_out_o", out_m, APB_DATA_W'(gpio_out_o));
            raw = rand32();
            write_reg(PERIPH_TIMER, TIMER_CMP, raw);
            cmp_m = raw & timer_mask;
            reload_m = rand32();
            write_reg(PERIPH_WDT, WDT_RELOAD, reload_m);
            mask_m = rand32();
            write_reg(PERIPH_EVENT, EVT_MASK, mask_m);

            read_expect("gpio_dir", PERIPH_GPIO, GPIO_DIR, dir_m);
            read_expect("gpio_out", PERIPH_GPIO, GPIO_OUT, out_m);
            read_expect("timer_cmp", PERIPH_TIMER, TIMER_CMP, cmp_m);
            read_expect("wdt_reload", PERIPH_WDT, WDT_RELOAD, reload_m);
            read_expect("evt_mask", PERIPH_EVENT, EVT_MASK, mask_m);
        end
    endtask

    task automatic decode_unmapped();
        logic [31:0] r;
        logic [31:0] o;
        apb_rsp_t    rsp;
        apb_rsp_t    err_rsp;
        err_rsp = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
        for (int i = 0; i < 6; i++) begin
            r = 4 + (rand32() % 12);
            o = rand32();
            apb_read(reg_addr(r[3:0], o[7:0] & 8'hFC), rsp);
            check_rsp("unmapped_read", err_rsp, rsp);
            apb_write(reg_addr(r[3:0], o[7:0] & 8'hFC), rand32(), rsp);
            check_bit("unmapped_write_pslverr", 1'b1, rsp.pslverr);
        end
    endtask

    task automatic gpio_interrupts();
        logic [NGPIO-1:0] flip;
        logic [NGPIO-1:0] hit;
        logic             seen;
        apb_rsp_t         rsp;
        for (int i = 0; i < 6; i++) begin
            gpio_in_i = rand32();
            repeat (3) @(negedge clk_i);
            read_expect("gpio_in", PERIPH_GPIO, GPIO_IN, APB_DATA_W'(gpio_in_i));

            inten_m = (i == 2) ? '0 : rand32();
            write_reg(PERIPH_GPIO, GPIO_INTEN, inten_m);
            mask_m = rand32();
            write_reg(PERIPH_EVENT, EVT_MASK, mask_m);
            // drop whatever the input change above left behind
            apb_read(reg_addr(PERIPH_GPIO, GPIO_INTSTATUS), rsp);

            flip      = rand32();
            hit       = flip & inten_m[NGPIO-1:0];
            gpio_in_i = gpio_in_i ^ flip;
            seen      = 1'b0;
            for (int k = 0; k < 6; k++) begin
                @(negedge clk_i);
                seen = seen | fc_events_o[EVT_GPIO];
            end
            check_bit("gpio_event", (|hit) & mask_m[EVT_GPIO], seen);
            read_expect("gpio_intstatus", PERIPH_GPIO, GPIO_INTSTATUS, APB_DATA_W'(hit));
            read_expect("gpio_intstatus_clear", PERIPH_GPIO, GPIO_INTSTATUS, '0);
        end
    endtask

    task automatic timer_period();
        int cycles;
        cmp_m  = 3 + (rand32() % 38);
        mask_m = mask_m | (32'd1 << EVT_TIMER);
        write_reg(PERIPH_EVENT, EVT_MASK, mask_m);
        write_reg(PERIPH_TIMER, TIMER_CMP, cmp_m);
        write_reg(PERIPH_TIMER, TIMER_COUNT, '0);
        write_reg(PERIPH_TIMER, TIMER_CFG, 32'd1);
        wait_event_bit(EVT_TIMER, 2 * cmp_m + 8, cycles);
        for (int p = 0; p < 4; p++) begin
            wait_event_bit(EVT_TIMER, cmp_m + 6, cycles);
            check_data("timer_period", cmp_m + 1, cycles);
        end
        write_reg(PERIPH_TIMER, TIMER_CFG, '0);
    endtask

    task automatic watchdog_expiry();
        logic [31:0] r;
        logic [7:0]  bad_key;
        reload_m = 5 + (rand32() % 56);
        write_reg(PERIPH_WDT, WDT_RELOAD, reload_m);
        write_reg(PERIPH_WDT, WDT_CTRL, 32'd1);
        for (int i = 0; i < reload_m; i++) begin
            check_bit("wdt_reset_low", 1'b0, wdt_reset_o);
            @(negedge clk_i);
        end
        wait_wdt_reset(3);

        r       = rand32();
        bad_key = r[7:0];
        if (bad_key == WDT_KICK_KEY) begin
            bad_key = ~bad_key;
        end
        write_reg(PERIPH_WDT, WDT_KICK, {24'h0, bad_key});
        check_bit("wdt_wrong_key", 1'b1, wdt_reset_o);
        @(negedge clk_i);
        check_bit("wdt_wrong_key_hold", 1'b1, wdt_reset_o);

        write_reg(PERIPH_WDT, WDT_KICK, 32'(WDT_KICK_KEY));
        check_bit("wdt_kick", 1'b0, wdt_reset_o);
        // one cycle of countdown passes before the access phase
        read_expect("wdt_count", PERIPH_WDT, WDT_COUNT, reload_m - 1);
        write_reg(PERIPH_WDT, WDT_CTRL, '0);
        // a disabled watchdog never expires
        for (int i = 0; i < reload_m + 2; i++) begin
            check_bit("wdt_disabled", 1'b0, wdt_reset_o);
            @(negedge clk_i);
        end
    endtask

    task automatic software_and_ref_events();
        logic [31:0] r;
        logic [7:0]  trig;
        int          cycles;
        for (int i = 0; i < 8; i++) begin
            mask_m = rand32();
            write_reg(PERIPH_EVENT, EVT_MASK, mask_m);
            r    = rand32();
            trig = r[7:0];
            write_reg(PERIPH_EVENT, EVT_SW_TRIG, r);
            check_events("sw_trig", FC_EVT_W'(trig & mask_m[7:0]), fc_events_o & 32'hFF);
            @(negedge clk_i);
            check_events("sw_trig_end", '0, fc_events_o & 32'hFF);
        end

        // only the reference edge left unmasked
        mask_m = 32'd1 << EVT_REF_EDGE;
        write_reg(PERIPH_EVENT, EVT_MASK, mask_m);
        for (int i = 0; i < 4; i++) begin
            wait_slow_toggle(20);
            wait_event_bit(EVT_REF_EDGE, 12, cycles);
            @(negedge clk_i);
            check_bit("ref_edge_single", 1'b0, fc_events_o[EVT_REF_EDGE]);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (rst_n_i === 1'b1) begin
            check_events("upper_bits_zero", '0, fc_events_o >> (EVT_REF_EDGE + 1));
        end
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk_i);
        fail_run("simulation ran too long without finishing");
    end

    initial begin
        rst_n_i   = 1'b0;
        apb_req_i = '0;
        gpio_in_i = '0;
        dir_m     = '0;
        out_m     = '0;
        inten_m   = '0;
        mask_m    = '0;
        cmp_m     = '0;
        reload_m  = '0;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        check_data("gpio_out_reset", '0, APB_DATA_W'(gpio_out_o));
        check_data("gpio_dir_reset", '0, APB_DATA_W'(gpio_dir_o));
        check_events("fc_events_reset", '0, fc_events_o);
        check_bit("wdt_reset_after_reset", 1'b0, wdt_reset_o);
        check_bit("pslverr_after_reset", 1'b0, apb_rsp_o.pslverr);

        registers_readback();
        decode_unmapped();
        gpio_interrupts();
        timer_period();
        watchdog_expiry();
        software_and_ref_events();

        $display("Test completed successfully");
        $finish;
    end

endmodule
